/* Makefile */
SIM := obj_dir/line_robot_sim

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output"
	@echo "make help   show this list"

test:
	verilator --binary --assert --top-module line_robot_tb -f all.f -o line_robot_sim
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

/* all.f */
source/sensor_pkg.sv
source/drive_pkg.sv
source/adc_controller.sv
source/line_follower.sv
source/pwm_generator.sv
source/line_robot_top.sv
dv/adc_model.sv
dv/line_robot_tb.sv

/* dv/adc_model.sv */
module adc_model
	import sensor_pkg::*;
#(
	parameter int CLK_PERIOD_NS = 40
)
(
	input  wire                 sck,
	input  wire                 cs_n,
	input  wire                 din,
	output logic                dout,
	input  wire [ADC_WIDTH-1:0] left_value,
	input  wire [ADC_WIDTH-1:0] center_value,
	input  wire [ADC_WIDTH-1:0] right_value,
	output logic                proto_error,
	output int                  frame_count
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam realtime HALF_NS = ADC_HALF_PERIOD * CLK_PERIOD_NS;

	int rise_cnt;
	int conv_idx;
	logic in_conv;
	logic sck_prev;
	logic cs_prev;
	logic [ADDR_BITS-1:0] addr_rx;
	logic [ADDR_BITS-1:0] addr_exp;
	logic [ADC_WIDTH-1:0] conv_value;
	realtime last_edge;

	// one process for all pins, so nothing is driven from two places
	initial begin
		dout = 1'b0;
		proto_error = 1'b0;
		frame_count = 0;
		rise_cnt = 0;
		conv_idx = 0;
		in_conv = 1'b0;
		sck_prev = sck;
		cs_prev = cs_n;
		addr_rx = '0;
		last_edge = 0;
		forever begin
			@(sck or cs_n);
			if (cs_n !== cs_prev) begin
				if (cs_n === 1'b0) begin
					// conversion starts, channel value fixed for its length
					if (conv_idx == 0) begin
						frame_count++;
					end
					in_conv = 1'b1;
					rise_cnt = 0;
					addr_rx = '0;
					last_edge = $realtime;
					case (conv_idx)
						0: conv_value = left_value;
						1: conv_value = center_value;
						default: conv_value = right_value;
					endcase
				end else if (cs_n === 1'b1 && in_conv) begin
					if (rise_cnt != SCK_PER_CONV) begin
						$display("adc_model: conversion ended after %0d sck periods", rise_cnt);
						proto_error = 1'b1;
					end
					in_conv = 1'b0;
					conv_idx = (conv_idx + 1) % NUM_CHANNELS;
					dout = 1'b0;
				end
			end
			if (sck !== sck_prev && in_conv && cs_n === 1'b0) begin
				if ($realtime - last_edge != HALF_NS) begin
					$display("adc_model: sck edge spacing of %0t is off", $realtime - last_edge);
					proto_error = 1'b1;
				end
				last_edge = $realtime;
				if (sck === 1'b1) begin
					rise_cnt++;
					if (rise_cnt >= ADDR_FIRST && rise_cnt < ADDR_FIRST + ADDR_BITS) begin
						addr_rx = {addr_rx[ADDR_BITS-2:0], din};
					end
					if (rise_cnt == ADDR_FIRST + ADDR_BITS - 1) begin
						addr_exp = (conv_idx == 0) ? CH_LEFT : (conv_idx == 1) ? CH_CENTER : CH_RIGHT;
						if (addr_rx != addr_exp) begin
							$display("adc_model: got address %0d, wanted %0d", addr_rx, addr_exp);
							proto_error = 1'b1;
						end
					end
				end else if (rise_cnt >= DATA_FIRST - 1 && rise_cnt <= SCK_PER_CONV - 1) begin
					// msb goes out ahead of the first data rising edge
					dout = conv_value[SCK_PER_CONV - 1 - rise_cnt];
				end
			end
			cs_prev = cs_n;
			sck_prev = sck;
		end
	end

endmodule

/* dv/line_robot_tb.sv */
module line_robot_tb
	import sensor_pkg::*, drive_pkg::*;
;

	timeunit 1ns;
	timeprecision 100ps;

	// 31 decisions of 2048 cycles plus the first frame, with margin
	localparam int TIMEOUT_CYCLES = 80000;
	localparam int PWM_PERIOD = (1 << DUTY_WIDTH) * PWM_PRESCALE;

	logic clk_50M;
	logic rst;
	logic key;
	logic armed;
	logic key_q;
	wire adc_dout;
	wire adc_sck;
	wire adc_cs_n;
	wire adc_din;
	wire motor_A1;
	wire motor_B1;
	wire motor_A2;
	wire motor_B2;
	wire [TURN_W-1:0] turn_flag;
	wire node_flag;
	wire [NODE_COUNT_W-1:0] fpga_led;
	wire proto_error;
	int frame_count;

	logic [ADC_WIDTH-1:0] left_value;
	logic [ADC_WIDTH-1:0] center_value;
	logic [ADC_WIDTH-1:0] right_value;
	logic [2:0] cur_pattern;
	logic [2:0] popped;
	logic [2:0] exp_q[$];
	integer seed;
	int cycle;
	int since_change;
	int frame_gap;
	int last_frames;

	// expected follower state, from the rule table
	logic [TURN_W-1:0] exp_turn;
	logic [DUTY_WIDTH-1:0] cmd1;
	logic [DUTY_WIDTH-1:0] cmd2;
	logic cmd_rev;
	logic exp_on_node;
	logic [NODE_COUNT_W-1:0] exp_count;

	int win;
	int a1_acc, b1_acc, a2_acc, b2_acc;
	int a1_tot, b1_tot, a2_tot, b2_tot;
	logic check_pwm;
	int exp_a1, exp_b1, exp_a2, exp_b2;

	line_robot_top UUT (
		.clk_50M   (clk_50M),
		.rst       (rst),
		.adc_dout  (adc_dout),
		.key       (key),
		.adc_sck   (adc_sck),
		.adc_cs_n  (adc_cs_n),
		.adc_din   (adc_din),
		.motor_A1  (motor_A1),
		.motor_B1  (motor_B1),
		.motor_A2  (motor_A2),
		.motor_B2  (motor_B2),
		.turn_flag (turn_flag),
		.node_flag (node_flag),
		.fpga_led  (fpga_led)
	);

	adc_model adc (
		.sck          (adc_sck),
		.cs_n         (adc_cs_n),
		.din          (adc_din),
		.dout         (adc_dout),
		.left_value   (left_value),
		.center_value (center_value),
		.right_value  (right_value),
		.proto_error  (proto_error),
		.frame_count  (frame_count)
	);

	initial begin
		clk_50M = 1'b0;
		forever #20 clk_50M = ~clk_50M;
	end

	task automatic report_failure(input string line);
		$display("%s", line);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	// pin expectations, pwm lands on B only when reversing
	always_comb begin
		exp_a1 = (armed && !cmd_rev) ? int'(cmd1) * PWM_PRESCALE : 0;
		exp_b1 = (armed && cmd_rev) ? int'(cmd1) * PWM_PRESCALE : 0;
		exp_a2 = (armed && !cmd_rev) ? int'(cmd2) * PWM_PRESCALE : 0;
		exp_b2 = (armed && cmd_rev) ? int'(cmd2) * PWM_PRESCALE : 0;
	end

	always @(posedge clk_50M) begin
		if (rst) begin
			exp_q.delete();
			exp_turn <= TURN_STRAIGHT;
			cmd1 <= '0;
			cmd2 <= '0;
			cmd_rev <= 1'b0;
			exp_on_node <= 1'b0;
			exp_count <= '0;
		end else begin
			if (UUT.credit_return) begin
				popped = exp_q.pop_front();
				exp_on_node <= (popped == 3'b111);
				if (popped == 3'b111 && !exp_on_node) begin
					exp_count <= exp_count + 1'b1;
				end
				case (popped)
					3'b010, 3'b111: begin
						exp_turn <= TURN_STRAIGHT;
						cmd1 <= FULL_DUTY;
						cmd2 <= FULL_DUTY;
						cmd_rev <= 1'b0;
					end
					3'b110, 3'b100: begin
						exp_turn <= TURN_LEFT;
						cmd1 <= SLOW_DUTY;
						cmd2 <= FULL_DUTY;
						cmd_rev <= 1'b0;
					end
					3'b011, 3'b001: begin
						exp_turn <= TURN_RIGHT;
						cmd1 <= FULL_DUTY;
						cmd2 <= SLOW_DUTY;
						cmd_rev <= 1'b0;
					end
					3'b000: begin
						exp_turn <= TURN_REVERSE;
						cmd1 <= SLOW_DUTY;
						cmd2 <= SLOW_DUTY;
						cmd_rev <= 1'b1;
					end
					default: begin
					end
				endcase
			end
			if (UUT.sample_valid) begin
				exp_q.push_back(cur_pattern);
			end
		end
	end

	// high counts per 128-cycle window, judged once the duty has settled
	always @(posedge clk_50M) begin
		key_q <= key;
		if (rst || UUT.credit_return || key != key_q) begin
			since_change <= 0;
		end else begin
			since_change <= since_change + 1;
		end
		if (rst) begin
			win <= 0;
			check_pwm <= 1'b0;
			{a1_acc, b1_acc, a2_acc, b2_acc} <= '0;
		end else begin
			check_pwm <= 1'b0;
			if (win == PWM_PERIOD - 1) begin
				a1_tot <= a1_acc + motor_A1;
				b1_tot <= b1_acc + motor_B1;
				a2_tot <= a2_acc + motor_A2;
				b2_tot <= b2_acc + motor_B2;
				{a1_acc, b1_acc, a2_acc, b2_acc} <= '0;
				win <= 0;
				check_pwm <= (since_change >= 3 * PWM_PERIOD);
			end else begin
				a1_acc <= a1_acc + motor_A1;
				b1_acc <= b1_acc + motor_B1;
				a2_acc <= a2_acc + motor_A2;
				b2_acc <= b2_acc + motor_B2;
				win <= win + 1;
			end
		end
	end

	always @(posedge clk_50M) begin
		if (rst) begin
			cycle <= 0;
			frame_gap <= 0;
			last_frames <= 0;
		end else begin
			cycle <= cycle + 1;
			last_frames <= frame_count;
			frame_gap <= (frame_count != last_frames) ? 0 : frame_gap + 1;
			if (cycle >= TIMEOUT_CYCLES) begin
				report_failure("Timeout: the test sequence did not finish in time");
			end
		end
	end

	a_turn: assert property (@(posedge clk_50M) disable iff (rst)
		UUT.credit_return |=> turn_flag == exp_turn)
		else report_failure($sformatf("ERROR %0t: turn_flag %0d, expected %0d",
			$time, turn_flag, exp_turn));

	a_count: assert property (@(posedge clk_50M) disable iff (rst)
		UUT.credit_return |=> fpga_led == exp_count)
		else report_failure($sformatf("ERROR %0t: node count %0d, expected %0d",
			$time, fpga_led, exp_count));

	a_flag_step: assert property (@(posedge clk_50M) disable iff (rst)
		node_flag |-> fpga_led == $past(fpga_led) + 8'd1)
		else report_failure($sformatf("ERROR %0t: node_flag without a count step", $time));

	a_no_step: assert property (@(posedge clk_50M) disable iff (rst)
		!node_flag |-> fpga_led == $past(fpga_led))
		else report_failure($sformatf("ERROR %0t: node count moved without node_flag", $time));

	a_pwm: assert property (@(posedge clk_50M) disable iff (rst)
		check_pwm |-> (a1_tot == exp_a1 && b1_tot == exp_b1 &&
			a2_tot == exp_a2 && b2_tot == exp_b2))
		else report_failure($sformatf("ERROR %0t: pwm highs %0d %0d %0d %0d, expected %0d %0d %0d %0d",
			$time, a1_tot, b1_tot, a2_tot, b2_tot, exp_a1, exp_b1, exp_a2, exp_b2));

	a_idle: assert property (@(posedge clk_50M) disable iff (rst)
		!key |-> !(motor_A1 || motor_B1 || motor_A2 || motor_B2))
		else report_failure($sformatf("ERROR %0t: motor pin high before start", $time));

	a_credit: assert property (@(posedge clk_50M) disable iff (rst)
		frame_count <= SAMPLE_CREDITS + cycle / DECISION_INTERVAL + 1)
		else report_failure($sformatf("ERROR %0t: %0d frames begun, more than credits allow",
			$time, frame_count));

	a_gap: assert property (@(posedge clk_50M) disable iff (rst)
		frame_gap <= 2 * DECISION_INTERVAL)
		else report_failure($sformatf("ERROR %0t: adc frames stopped", $time));

	a_cs_idle: assert property (@(posedge clk_50M) disable iff (rst)
		frame_count == 0 |-> adc_cs_n)
		else report_failure($sformatf("ERROR %0t: adc_cs_n low before first frame", $time));

	a_proto: assert property (@(posedge clk_50M) disable iff (rst)
		!proto_error)
		else report_failure($sformatf("ERROR %0t: adc protocol violation", $time));

	// readings sit far from the threshold, noise never crosses it
	task automatic set_readings(input logic [2:0] pat);
		left_value = pat[2] ? 12'd3000 + 12'($random(seed) & 255) : 12'd500 + 12'($random(seed) & 255);
		center_value = pat[1] ? 12'd3000 + 12'($random(seed) & 255) : 12'd500 + 12'($random(seed) & 255);
		right_value = pat[0] ? 12'd3000 + 12'($random(seed) & 255) : 12'd500 + 12'($random(seed) & 255);
		cur_pattern = pat;
	endtask

	// change readings right after a frame ends, then let decisions pass
	task automatic hold_pattern(input logic [2:0] pat, input int decisions);
		do @(negedge clk_50M); while (!UUT.sample_valid);
		// the finished frame is queued first, with the pattern it carried
		@(negedge clk_50M);
		set_readings(pat);
		repeat (decisions) begin
			do @(negedge clk_50M); while (!UUT.credit_return);
		end
	endtask

	initial begin
		seed = 32'hbc57_ca19;
		rst = 1'b1;
		key = 1'b0;
		armed = 1'b0;
		set_readings(3'b010);
		repeat (3) @(posedge clk_50M);
		@(negedge clk_50M);
		rst = 1'b0;

		// motors must stay off until the key
		hold_pattern(3'b110, 3);
		hold_pattern(3'b000, 3);

		@(negedge clk_50M);
		key = 1'b1;
		armed = 1'b1;

		hold_pattern(3'b010, 3);
		hold_pattern(3'b100, 3);
		hold_pattern(3'b011, 3);
		hold_pattern(3'b000, 3);
		hold_pattern(3'b101, 3);
		hold_pattern(3'b111, 4);
		hold_pattern(3'b001, 3);
		hold_pattern(3'b111, 3);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* source/adc_controller.sv */
module adc_controller
	import sensor_pkg::*, drive_pkg::*;
(
	input  wire                  clk_50M,
	input  wire                  rst,
	input  wire                  adc_dout,
	output logic                 adc_sck,
	output logic                 adc_cs_n,
	output logic                 adc_din,
	output logic [ADC_WIDTH-1:0] left_value,
	output logic [ADC_WIDTH-1:0] center_value,
	output logic [ADC_WIDTH-1:0] right_value,
	output logic                 sample_valid,
	input  wire                  credit_return
);

	typedef enum logic [1:0] {S_IDLE, S_CONV, S_GAP} adc_state_t;

	adc_state_t state;
	logic [ADC_DIV_W-1:0] div_cnt;
	logic [SCK_CNT_W-1:0] period;
	logic [SCK_CNT_W-1:0] next_period;
	logic [SCK_CNT_W-1:0] addr_pos;
	logic [CH_IDX_W-1:0] ch_idx;
	logic [ADDR_BITS-1:0] ch_addr;
	logic [CREDIT_W-1:0] credits;
	logic [ADC_WIDTH-1:0] shift_in;
	logic [ADC_WIDTH-1:0] result;
	logic edge_tick;
	logic frame_start;
	logic bit_sample;
	logic last_ch;
	logic next_din;

	assign edge_tick = (div_cnt == ADC_DIV_W'(ADC_HALF_PERIOD - 1));
	assign frame_start = (state == S_IDLE) && (credits != '0);
	assign last_ch = (ch_idx == CH_IDX_W'(NUM_CHANNELS - 1));
	assign result = {shift_in[ADC_WIDTH-2:0], adc_dout};

	// dout is taken on the sck rising edge of the data periods
	assign bit_sample = (state == S_CONV) && edge_tick && !adc_sck && (period >= DATA_FIRST);

	always_comb begin
		case (ch_idx)
			CH_IDX_W'(0): ch_addr = CH_LEFT;
			CH_IDX_W'(1): ch_addr = CH_CENTER;
			default: ch_addr = CH_RIGHT;
		endcase
	end

	// din for the period that starts at the coming falling edge
	assign next_period = period + 1'b1;
	assign addr_pos = next_period - SCK_CNT_W'(ADDR_FIRST);

	always_comb begin
		next_din = 1'b0;
		if (next_period >= ADDR_FIRST && addr_pos < ADDR_BITS) begin
			next_din = ch_addr[2'd2 - addr_pos[1:0]];
		end
	end

	// a return and a start in the same cycle leave the count alone
	always_ff @(posedge clk_50M) begin
		if (rst) begin
			credits <= CREDIT_W'(SAMPLE_CREDITS);
		end else if (frame_start && !credit_return) begin
			credits <= credits - 1'b1;
		end else if (credit_return && !frame_start) begin
			credits <= credits + 1'b1;
		end
	end

	always_ff @(posedge clk_50M) begin
		if (rst) begin
			state <= S_IDLE;
			adc_sck <= 1'b0;
			adc_cs_n <= 1'b1;
			adc_din <= 1'b0;
			div_cnt <= '0;
			period <= '0;
			ch_idx <= '0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= 1'b0;
			case (state)
				S_IDLE: begin
					div_cnt <= '0;
					if (frame_start) begin
						state <= S_CONV;
						adc_cs_n <= 1'b0;
						adc_din <= 1'b0;
						ch_idx <= '0;
						period <= SCK_CNT_W'(1);
					end
				end
				S_CONV: begin
					div_cnt <= edge_tick ? '0 : div_cnt + 1'b1;
					if (edge_tick && !adc_sck) begin
						adc_sck <= 1'b1;
						if (bit_sample && period == SCK_CNT_W'(SCK_PER_CONV) && last_ch) begin
							sample_valid <= 1'b1;
						end
					end else if (edge_tick) begin
						adc_sck <= 1'b0;
						if (period == SCK_CNT_W'(SCK_PER_CONV)) begin
							// conversion done, cs_n up for one sck period
							state <= S_GAP;
							adc_cs_n <= 1'b1;
							adc_din <= 1'b0;
							period <= '0;
						end else begin
							period <= next_period;
							adc_din <= next_din;
						end
					end
				end
				S_GAP: begin
					div_cnt <= edge_tick ? '0 : div_cnt + 1'b1;
					if (edge_tick && period == SCK_CNT_W'(1)) begin
						if (last_ch) begin
							state <= S_IDLE;
						end else begin
							state <= S_CONV;
							adc_cs_n <= 1'b0;
							ch_idx <= ch_idx + 1'b1;
							period <= SCK_CNT_W'(1);
						end
					end else if (edge_tick) begin
						period <= next_period;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// shift register and result latches
	always_ff @(posedge clk_50M) begin
		if (bit_sample) begin
			shift_in <= result;
			if (period == SCK_CNT_W'(SCK_PER_CONV)) begin
				case (ch_idx)
					CH_IDX_W'(0): left_value <= result;
					CH_IDX_W'(1): center_value <= result;
					default: right_value <= result;
				endcase
			end
		end
	end

endmodule

/* source/drive_pkg.sv */
package drive_pkg;

	// duty is high slots out of 32
	localparam int DUTY_WIDTH = 5;
	localparam logic [DUTY_WIDTH-1:0] FULL_DUTY = 5'd24;
	localparam logic [DUTY_WIDTH-1:0] SLOW_DUTY = 5'd8;

	// clk_50M cycles per pwm slot
	localparam int PWM_PRESCALE = 4;
	localparam int PRESCALE_W = $clog2(PWM_PRESCALE);

	// minimum spacing of two follower decisions
	localparam int DECISION_INTERVAL = 2048;
	localparam int INTERVAL_W = $clog2(DECISION_INTERVAL);

	// sample queue depth, also the credits the adc starts with
	localparam int SAMPLE_CREDITS = 2;
	localparam int CREDIT_W = $clog2(SAMPLE_CREDITS + 1);
	localparam int QUEUE_PTR_W = $clog2(SAMPLE_CREDITS);

	localparam int NODE_COUNT_W = 8;

	// motion decision codes on turn_flag
	localparam int TURN_W = 2;
	localparam logic [TURN_W-1:0] TURN_STRAIGHT = 2'd0;
	localparam logic [TURN_W-1:0] TURN_LEFT = 2'd1;
	localparam logic [TURN_W-1:0] TURN_RIGHT = 2'd2;
	localparam logic [TURN_W-1:0] TURN_REVERSE = 2'd3;

endpackage

/* source/line_follower.sv */
module line_follower
	import sensor_pkg::*, drive_pkg::*;
(
	input  wire                     clk_50M,
	input  wire                     rst,
	input  wire                     key,
	input  wire [ADC_WIDTH-1:0]     left_value,
	input  wire [ADC_WIDTH-1:0]     center_value,
	input  wire [ADC_WIDTH-1:0]     right_value,
	input  wire                     sample_valid,
	output logic                    credit_return,
	output logic [DUTY_WIDTH-1:0]   dc1,
	output logic [DUTY_WIDTH-1:0]   dc2,
	output logic                    reverse,
	output logic [TURN_W-1:0]       turn_flag,
	output logic                    node_flag,
	output logic [NODE_COUNT_W-1:0] node_count
);

	logic [3*ADC_WIDTH-1:0] queue_mem [SAMPLE_CREDITS];
	logic [QUEUE_PTR_W-1:0] wr_ptr;
	logic [QUEUE_PTR_W-1:0] rd_ptr;
	logic [CREDIT_W-1:0] fill;
	logic [INTERVAL_W-1:0] interval_cnt;
	logic [3*ADC_WIDTH-1:0] head;
	logic [2:0] black;
	logic interval_done;
	logic pop;
	logic key_meta;
	logic key_sync;
	logic key_prev;
	logic run;
	logic on_node;
	logic [DUTY_WIDTH-1:0] cmd_dc1;
	logic [DUTY_WIDTH-1:0] cmd_dc2;
	logic cmd_reverse;

	assign interval_done = (interval_cnt == INTERVAL_W'(DECISION_INTERVAL - 1));
	assign pop = interval_done && (fill != '0);
	assign head = queue_mem[rd_ptr];

	// black pattern as left, center, right
	assign black[2] = head[3*ADC_WIDTH-1 -: ADC_WIDTH] > LINE_THRESHOLD;
	assign black[1] = head[2*ADC_WIDTH-1 -: ADC_WIDTH] > LINE_THRESHOLD;
	assign black[0] = head[ADC_WIDTH-1:0] > LINE_THRESHOLD;

	always_ff @(posedge clk_50M) begin
		if (sample_valid) begin
			queue_mem[wr_ptr] <= {left_value, center_value, right_value};
		end
	end

	// queue pointers, never full thanks to the credits
	always_ff @(posedge clk_50M) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (sample_valid) begin
				wr_ptr <= (wr_ptr == QUEUE_PTR_W'(SAMPLE_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == QUEUE_PTR_W'(SAMPLE_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (sample_valid && !pop) begin
				fill <= fill + 1'b1;
			end else if (pop && !sample_valid) begin
				fill <= fill - 1'b1;
			end
		end
	end

	// decision spacing, restarts at every pop
	always_ff @(posedge clk_50M) begin
		if (rst) begin
			interval_cnt <= '0;
		end else if (pop) begin
			interval_cnt <= '0;
		end else if (!interval_done) begin
			interval_cnt <= interval_cnt + 1'b1;
		end
	end

	// start button, first rising edge arms the motors
	always_ff @(posedge clk_50M) begin
		if (rst) begin
			key_meta <= 1'b0;
			key_sync <= 1'b0;
			key_prev <= 1'b0;
			run <= 1'b0;
		end else begin
			key_meta <= key;
			key_sync <= key_meta;
			key_prev <= key_sync;
			if (key_sync && !key_prev) begin
				run <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_50M) begin
		if (rst) begin
			credit_return <= 1'b0;
			node_flag <= 1'b0;
			node_count <= '0;
			on_node <= 1'b0;
			turn_flag <= TURN_STRAIGHT;
			cmd_dc1 <= '0;
			cmd_dc2 <= '0;
			cmd_reverse <= 1'b0;
		end else begin
			credit_return <= pop;
			node_flag <= 1'b0;
			if (pop) begin
				on_node <= (black == 3'b111);
				if (black == 3'b111 && !on_node) begin
					node_flag <= 1'b1;
					node_count <= node_count + 1'b1;
				end
				case (black)
					3'b010, 3'b111: begin
						turn_flag <= TURN_STRAIGHT;
						cmd_dc1 <= FULL_DUTY;
						cmd_dc2 <= FULL_DUTY;
						cmd_reverse <= 1'b0;
					end
					3'b110, 3'b100: begin
						turn_flag <= TURN_LEFT;
						cmd_dc1 <= SLOW_DUTY;
						cmd_dc2 <= FULL_DUTY;
						cmd_reverse <= 1'b0;
					end
					3'b011, 3'b001: begin
						turn_flag <= TURN_RIGHT;
						cmd_dc1 <= FULL_DUTY;
						cmd_dc2 <= SLOW_DUTY;
						cmd_reverse <= 1'b0;
					end
					3'b000: begin
						// lost the line, back up slowly
						turn_flag <= TURN_REVERSE;
						cmd_dc1 <= SLOW_DUTY;
						cmd_dc2 <= SLOW_DUTY;
						cmd_reverse <= 1'b1;
					end
					default: begin
						// 101 is ambiguous, hold last command
					end
				endcase
			end
		end
	end

	assign dc1 = run ? cmd_dc1 : '0;
	assign dc2 = run ? cmd_dc2 : '0;
	assign reverse = run & cmd_reverse;

endmodule

/* source/line_robot_top.sv */
module line_robot_top
	import sensor_pkg::*, drive_pkg::*;
(
	input  wire                    clk_50M,
	input  wire                    rst,
	input  wire                    adc_dout,
	input  wire                    key,
	output wire                    adc_sck,
	output wire                    adc_cs_n,
	output wire                    adc_din,
	output wire                    motor_A1,
	output wire                    motor_B1,
	output wire                    motor_A2,
	output wire                    motor_B2,
	output wire [TURN_W-1:0]       turn_flag,
	output wire                    node_flag,
	output wire [NODE_COUNT_W-1:0] fpga_led
);

	wire [ADC_WIDTH-1:0] left_value;
	wire [ADC_WIDTH-1:0] center_value;
	wire [ADC_WIDTH-1:0] right_value;
	wire sample_valid;
	wire credit_return;
	wire [DUTY_WIDTH-1:0] dc1;
	wire [DUTY_WIDTH-1:0] dc2;
	wire reverse;

	adc_controller u_adc (
		.clk_50M       (clk_50M),
		.rst           (rst),
		.adc_dout      (adc_dout),
		.adc_sck       (adc_sck),
		.adc_cs_n      (adc_cs_n),
		.adc_din       (adc_din),
		.left_value    (left_value),
		.center_value  (center_value),
		.right_value   (right_value),
		.sample_valid  (sample_valid),
		.credit_return (credit_return)
	);

	line_follower u_follower (
		.clk_50M       (clk_50M),
		.rst           (rst),
		.key           (key),
		.left_value    (left_value),
		.center_value  (center_value),
		.right_value   (right_value),
		.sample_valid  (sample_valid),
		.credit_return (credit_return),
		.dc1           (dc1),
		.dc2           (dc2),
		.reverse       (reverse),
		.turn_flag     (turn_flag),
		.node_flag     (node_flag),
		.node_count    (fpga_led)
	);

	// motor 1
	pwm_generator u_pwm1 (
		.clk_50M    (clk_50M),
		.rst        (rst),
		.duty_cycle (dc1),
		.reverse    (reverse),
		.motor_a    (motor_A1),
		.motor_b    (motor_B1)
	);

	// motor 2
	pwm_generator u_pwm2 (
		.clk_50M    (clk_50M),
		.rst        (rst),
		.duty_cycle (dc2),
		.reverse    (reverse),
		.motor_a    (motor_A2),
		.motor_b    (motor_B2)
	);

endmodule

/* source/pwm_generator.sv */
module pwm_generator
	import drive_pkg::*;
(
	input  wire                  clk_50M,
	input  wire                  rst,
	input  wire [DUTY_WIDTH-1:0] duty_cycle,
	input  wire                  reverse,
	output logic                 motor_a,
	output logic                 motor_b
);

	logic [PRESCALE_W-1:0] pre_cnt;
	logic [DUTY_WIDTH-1:0] slot;
	logic [DUTY_WIDTH-1:0] duty_q;
	logic reverse_q;
	logic slot_tick;
	logic wrap;
	logic pwm_on;

	assign slot_tick = (pre_cnt == PRESCALE_W'(PWM_PRESCALE - 1));
	assign wrap = slot_tick && (slot == '1);
	assign pwm_on = (slot < duty_q);

	// prescaler and 32-slot period
	always_ff @(posedge clk_50M) begin
		if (rst) begin
			pre_cnt <= '0;
			slot <= '0;
		end else begin
			pre_cnt <= slot_tick ? '0 : pre_cnt + 1'b1;
			if (slot_tick) begin
				slot <= slot + 1'b1;
			end
		end
	end

	// new command only at a period boundary
	always_ff @(posedge clk_50M) begin
		if (rst) begin
			duty_q <= '0;
			reverse_q <= 1'b0;
		end else if (wrap) begin
			duty_q <= duty_cycle;
			reverse_q <= reverse;
		end
	end

	// steer pwm to one side of the bridge, other side held low
	always_ff @(posedge clk_50M) begin
		if (rst) begin
			motor_a <= 1'b0;
			motor_b <= 1'b0;
		end else begin
			motor_a <= pwm_on & ~reverse_q;
			motor_b <= pwm_on & reverse_q;
		end
	end

endmodule

/* source/sensor_pkg.sv */
package sensor_pkg;

	// one conversion result
	localparam int ADC_WIDTH = 12;

	// adc_sck half period in clk_50M cycles
	localparam int ADC_HALF_PERIOD = 8;
	localparam int ADC_DIV_W = $clog2(ADC_HALF_PERIOD);

	// sck periods while cs_n is low for one conversion
	localparam int SCK_PER_CONV = 16;
	localparam int SCK_CNT_W = $clog2(SCK_PER_CONV + 1);

	// address goes out in periods 3..5, data comes back in 5..16
	localparam int ADDR_FIRST = 3;
	localparam int DATA_FIRST = SCK_PER_CONV - ADC_WIDTH + 1;

	// channels read per frame, in this order
	localparam int NUM_CHANNELS = 3;
	localparam int CH_IDX_W = $clog2(NUM_CHANNELS);
	localparam int ADDR_BITS = 3;

	localparam logic [ADDR_BITS-1:0] CH_LEFT = 3'd0;
	localparam logic [ADDR_BITS-1:0] CH_CENTER = 3'd1;
	localparam logic [ADDR_BITS-1:0] CH_RIGHT = 3'd2;

	// above this the sensor sees black
	localparam logic [ADC_WIDTH-1:0] LINE_THRESHOLD = 12'd1800;

endpackage
